// File: project.f
rtl/preview_pkg.sv
rtl/preview_fifo.sv
rtl/preview_cfg.sv
rtl/preview_top.sv
testbench/tb_clock.sv
testbench/preview_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the preview FIFO testbench with Verilator.
# Exit status is 0 only when the pass line appears in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module preview_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "run_sim: Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vpreview_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "run_sim: simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
  echo "run_sim: PASS"
  exit 0
fi
echo "run_sim: FAIL"
exit 1

// File: testbench/preview_tb.sv
// ----------------------------------------------------------------------
// testbench for preview_top with inputs changed on the falling edge
// the queue model follows each rising edge half a cycle later
// concurrent assertions compare the DUT with that model
// random stimulus is reproducible
// the run ends on a cycle limit
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module preview_tb
  import preview_pkg::*;
;

  // cycle budget per test
  localparam int len_reset = 10;
  localparam int len_order = 400;
  localparam int len_full  = 30;
  localparam int len_unf   = 20;
  localparam int len_flush = 60;
  localparam int max_cycles = 4 + len_reset + len_order + len_full + len_unf + len_flush + 200;

  logic                  clk;
  logic                  rst_n;
  logic                  wrreq;
  logic                  ena;
  logic [data_w-1:0]     id0;
  logic [data_w-1:0]     id1;
  logic [shift_w-1:0]    shift_req_oh;
  logic                  valid;
  logic                  valid2;
  logic [data_w-1:0]     od0;
  logic [data_w-1:0]     od1;
  logic                  cfg_wr;
  logic [cfg_addr_w-1:0] cfg_addr;
  logic [cfg_data_w-1:0] cfg_wdata;
  logic [cfg_data_w-1:0] cfg_rdata;
  logic [level_w-1:0]    level;
  logic                  almost_full;

  // reference model state
  logic [data_w-1:0]     model_q[$];
  logic                  m_enable;
  logic                  m_flush;
  logic [cfg_data_w-1:0] m_thresh;
  logic [cfg_data_w-1:0] m_ovf;
  logic [cfg_data_w-1:0] m_unf;
  logic                  m_ovf_pend;
  logic                  m_unf_pend;

  // expected outputs
  logic [level_w-1:0]    exp_level;
  logic                  exp_valid;
  logic                  exp_valid2;
  logic [data_w-1:0]     exp_od0;
  logic [data_w-1:0]     exp_od1;
  logic                  exp_af;
  logic [cfg_data_w-1:0] exp_rdata;

  logic check_on;
  int   err_count;
  int   tests_run;
  int   tests_failed;
  int   cycle_cnt;
  int   seed;

  tb_clock u_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  preview_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .wrreq        (wrreq),
    .ena          (ena),
    .id0          (id0),
    .id1          (id1),
    .shift_req_oh (shift_req_oh),
    .valid        (valid),
    .valid2       (valid2),
    .od0          (od0),
    .od1          (od1),
    .cfg_wr       (cfg_wr),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .cfg_rdata    (cfg_rdata),
    .level        (level),
    .almost_full  (almost_full)
  );

  task automatic log_mismatch(input string what, input int got, input int exp);
    err_count++;
    $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
  endtask

  // ----------------------------------------------------------------------
  // checks against the model
  // ----------------------------------------------------------------------
  a_level : assert property (@(posedge clk) disable iff (!check_on) level == exp_level)
    else log_mismatch("level", int'($sampled(level)), int'(exp_level));
  a_valid : assert property (@(posedge clk) disable iff (!check_on) valid == exp_valid)
    else log_mismatch("valid", int'($sampled(valid)), int'(exp_valid));
  a_valid2 : assert property (@(posedge clk) disable iff (!check_on) valid2 == exp_valid2)
    else log_mismatch("valid2", int'($sampled(valid2)), int'(exp_valid2));
  a_od0 : assert property (@(posedge clk) disable iff (!check_on) exp_valid |-> od0 == exp_od0)
    else log_mismatch("od0", int'($sampled(od0)), int'(exp_od0));
  a_od1 : assert property (@(posedge clk) disable iff (!check_on) exp_valid2 |-> od1 == exp_od1)
    else log_mismatch("od1", int'($sampled(od1)), int'(exp_od1));
  a_af : assert property (@(posedge clk) disable iff (!check_on) almost_full == exp_af)
    else log_mismatch("almost_full", int'($sampled(almost_full)), int'(exp_af));
  a_rdata : assert property (@(posedge clk) disable iff (!check_on) cfg_rdata == exp_rdata)
    else log_mismatch("cfg_rdata", int'($sampled(cfg_rdata)), int'(exp_rdata));

  // register read view of the model
  always_comb begin
    exp_rdata = '0;
    case (cfg_addr)
      reg_ctrl:   exp_rdata[ctrl_enable_bit] = m_enable;
      reg_thresh: exp_rdata = m_thresh;
      reg_ovf:    exp_rdata = m_ovf;
      default:    exp_rdata = m_unf;
    endcase
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      $display("timeout: run went past %0d cycles without finishing", max_cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  task automatic refresh_expect();
    exp_level  = level_w'(model_q.size());
    exp_valid  = model_q.size() >= 1;
    exp_valid2 = model_q.size() >= 2;
    exp_od0    = (model_q.size() >= 1) ? model_q[0] : '0;
    exp_od1    = (model_q.size() >= 2) ? model_q[1] : '0;
    exp_af     = model_q.size() >= int'(m_thresh);
  endtask

  // one rising edge with the inputs currently driven
  task automatic apply_model();
    int   n_shift;
    int   n_wr;
    logic ovf_now;
    logic unf_now;
    logic ctrl_wr;
    logic flush_req;
    ctrl_wr   = cfg_wr && (cfg_addr == reg_ctrl);
    flush_req = ctrl_wr && cfg_wdata[ctrl_flush_bit];
    ovf_now   = 1'b0;
    unf_now   = 1'b0;
    // counters see the pulses of the previous edge
    if (flush_req) begin
      m_ovf = '0;
      m_unf = '0;
    end else begin
      if (m_ovf_pend && m_ovf != '1) m_ovf = m_ovf + 16'd1;
      if (m_unf_pend && m_unf != '1) m_unf = m_unf + 16'd1;
    end
    if (m_flush) begin
      model_q.delete();
    end else begin
      n_shift = (shift_req_oh == shift_two) ? 2 : (shift_req_oh == shift_one) ? 1 : 0;
      if (n_shift > model_q.size()) begin
        unf_now = 1'b1;
      end else begin
        repeat (n_shift) void'(model_q.pop_front());
      end
      n_wr = !wrreq ? 0 : (ena ? 2 : 1);
      if (m_enable && n_wr > 0) begin
        if (model_q.size() + n_wr > fifo_depth) begin
          ovf_now = 1'b1;
        end else begin
          model_q.push_back(id0);
          if (n_wr == 2) model_q.push_back(id1);
        end
      end
    end
    m_ovf_pend = ovf_now;
    m_unf_pend = unf_now;
    m_flush    = flush_req;
    if (ctrl_wr) m_enable = cfg_wdata[ctrl_enable_bit];
    if (cfg_wr && cfg_addr == reg_thresh) m_thresh = cfg_wdata;
    refresh_expect();
  endtask

  // ----------------------------------------------------------------------
  // stimulus helpers entered and left on a falling edge
  // ----------------------------------------------------------------------
  task automatic tick();
    @(posedge clk);
    @(negedge clk);
    apply_model();
  endtask

  task automatic idle(input int n);
    repeat (n) tick();
  endtask

  task automatic push_words(input int n);
    logic [31:0] d;
    d     = $random(seed);
    wrreq = 1'b1;
    ena   = (n == 2);
    id0   = d[15:0];
    id1   = d[31:16];
    tick();
    wrreq = 1'b0;
    ena   = 1'b0;
  endtask

  task automatic retire_words(input int n);
    shift_req_oh = (n == 2) ? shift_two : (n == 1) ? shift_one : shift_hold;
    tick();
    shift_req_oh = shift_hold;
  endtask

  task automatic write_reg(input logic [cfg_addr_w-1:0] addr, input logic [cfg_data_w-1:0] data);
    cfg_wr    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    tick();
    cfg_wr    = 1'b0;
    cfg_wdata = '0;
  endtask

  // the rdata assertion does the comparison at the next rising edge
  task automatic read_reg(input logic [cfg_addr_w-1:0] addr);
    cfg_addr = addr;
    tick();
  endtask

  task automatic close_test(input string name, input int errs_at_start);
    int n;
    tick();
    n = err_count - errs_at_start;
    tests_run++;
    if (n != 0) tests_failed++;
    $display("test %0d %s: %s, %0d mismatches", tests_run, name, (n == 0) ? "ok" : "failed", n);
  endtask

  initial begin
    int          e0;
    int          n;
    logic [31:0] r;
    seed         = 70;
    wrreq        = 1'b0;
    ena          = 1'b0;
    id0          = '0;
    id1          = '0;
    shift_req_oh = shift_hold;
    cfg_wr       = 1'b0;
    cfg_addr     = reg_ctrl;
    cfg_wdata    = '0;
    check_on     = 1'b0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    cycle_cnt    = 0;
    m_enable     = 1'b1;
    m_flush      = 1'b0;
    m_thresh     = thresh_reset;
    m_ovf        = '0;
    m_unf        = '0;
    m_ovf_pend   = 1'b0;
    m_unf_pend   = 1'b0;
    refresh_expect();
    wait (rst_n === 1'b1);
    check_on = 1'b1;

    e0 = err_count;
    read_reg(reg_ovf);
    read_reg(reg_unf);
    close_test("reset_state", e0);

    // random single and double writes with retires capped at the level
    e0 = err_count;
    for (int i = 0; i < len_order; i++) begin
      r     = $random(seed);
      wrreq = r[0] | r[1];
      ena   = r[2];
      {id1, id0} = $random(seed);
      n = (r[5:4] == 2'b00) ? 0 : (r[5:4] == 2'b01) ? 1 : 2;
      if (n > model_q.size()) n = model_q.size();
      shift_req_oh = (n == 2) ? shift_two : (n == 1) ? shift_one : shift_hold;
      tick();
    end
    wrreq        = 1'b0;
    ena          = 1'b0;
    shift_req_oh = shift_hold;
    close_test("order_preview", e0);

    e0 = err_count;
    write_reg(reg_ctrl, 16'h0003);
    idle(2);
    repeat (8) push_words(2);
    repeat (3) push_words(1);
    idle(2);
    read_reg(reg_ovf);
    close_test("full", e0);

    e0 = err_count;
    write_reg(reg_ctrl, 16'h0003);
    idle(2);
    retire_words(2);
    retire_words(2);
    push_words(1);
    retire_words(2);
    idle(2);
    read_reg(reg_unf);
    close_test("underrun", e0);

    // both counters are nonzero when the flush clears them
    // disabled writes with room left are dropped silently
    e0 = err_count;
    repeat (10) push_words(2);
    write_reg(reg_ctrl, 16'h0003);
    idle(2);
    read_reg(reg_ovf);
    read_reg(reg_unf);
    repeat (7) push_words(2);
    write_reg(reg_ctrl, 16'h0000);
    repeat (2) push_words(2);
    push_words(1);
    idle(2);
    read_reg(reg_ovf);
    read_reg(reg_ctrl);
    write_reg(reg_ctrl, 16'h0003);
    idle(2);
    write_reg(reg_thresh, 16'd4);
    repeat (2) push_words(2);
    retire_words(1);
    read_reg(reg_thresh);
    close_test("flush_disable", e0);

    $display("tests run %0d, tests failed %0d, check errors %0d", tests_run, tests_failed,
             err_count);
    if (err_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
// ----------------------------------------------------------------------
// testbench clock and reset, 10 ns period
// rst_n is held low over the first 4 rising edges, then released
// on a falling edge
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: rtl/preview_top.sv
// ----------------------------------------------------------------------
// preview FIFO with its register block, single clock
// no back-pressure, the producer watches level or almost_full
// excess writes are dropped and counted in the ovf register
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module preview_top
  import preview_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // producer
  input  logic                  wrreq,
  input  logic                  ena,
  input  logic [data_w-1:0]     id0,
  input  logic [data_w-1:0]     id1,

  // consumer
  input  logic [shift_w-1:0]    shift_req_oh,
  output logic                  valid,
  output logic                  valid2,
  output logic [data_w-1:0]     od0,
  output logic [data_w-1:0]     od1,

  // config bus
  input  logic                  cfg_wr,
  input  logic [cfg_addr_w-1:0] cfg_addr,
  input  logic [cfg_data_w-1:0] cfg_wdata,
  output logic [cfg_data_w-1:0] cfg_rdata,

  // status
  output logic [level_w-1:0]    level,
  output logic                  almost_full
);

  logic enable;
  logic flush;
  logic ovf_pulse;
  logic unf_pulse;

  preview_fifo u_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .wrreq        (wrreq),
    .ena          (ena),
    .id0          (id0),
    .id1          (id1),
    .shift_req_oh (shift_req_oh),
    .enable       (enable),
    .flush        (flush),
    .valid        (valid),
    .valid2       (valid2),
    .od0          (od0),
    .od1          (od1),
    .level        (level),
    .ovf_pulse    (ovf_pulse),
    .unf_pulse    (unf_pulse)
  );

  preview_cfg u_cfg (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .cfg_rdata   (cfg_rdata),
    .level       (level),
    .ovf_pulse   (ovf_pulse),
    .unf_pulse   (unf_pulse),
    .enable      (enable),
    .flush       (flush),
    .almost_full (almost_full)
  );

endmodule

`default_nettype wire

// File: rtl/preview_cfg.sv
// ----------------------------------------------------------------------
// control and status registers of the preview FIFO on a strobe bus
// flush is a one-cycle pulse in the cycle after the ctrl write
// the same ctrl write clears both counters, ahead of any pending pulse
// counters saturate at all ones, reads are combinational
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module preview_cfg
  import preview_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  // register bus
  input  logic                  cfg_wr,
  input  logic [cfg_addr_w-1:0] cfg_addr,
  input  logic [cfg_data_w-1:0] cfg_wdata,
  output logic [cfg_data_w-1:0] cfg_rdata,

  // FIFO status
  input  logic [level_w-1:0]    level,
  input  logic                  ovf_pulse,
  input  logic                  unf_pulse,

  // FIFO control
  output logic                  enable,
  output logic                  flush,
  output logic                  almost_full
);

  logic [cfg_data_w-1:0] thresh;
  logic [cfg_data_w-1:0] ovf_cnt;
  logic [cfg_data_w-1:0] unf_cnt;

  logic ctrl_wr;
  logic thresh_wr;
  logic flush_req;

  assign ctrl_wr   = cfg_wr && (cfg_addr == reg_ctrl);
  assign thresh_wr = cfg_wr && (cfg_addr == reg_thresh);
  assign flush_req = ctrl_wr && cfg_wdata[ctrl_flush_bit];

  // ----------------------------------------------------------------------
  // ctrl and threshold
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      enable <= 1'b1;
      flush  <= 1'b0;
      thresh <= thresh_reset;
    end else begin
      // flush bit is self-clearing
      flush <= flush_req;
      if (ctrl_wr) begin
        enable <= cfg_wdata[ctrl_enable_bit];
      end
      if (thresh_wr) begin
        thresh <= cfg_wdata;
      end
    end
  end

  // ----------------------------------------------------------------------
  // event counters
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ovf_cnt <= '0;
      unf_cnt <= '0;
    end else if (flush_req) begin
      ovf_cnt <= '0;
      unf_cnt <= '0;
    end else begin
      if (ovf_pulse && (ovf_cnt != '1)) begin
        ovf_cnt <= ovf_cnt + 1'b1;
      end
      if (unf_pulse && (unf_cnt != '1)) begin
        unf_cnt <= unf_cnt + 1'b1;
      end
    end
  end

  // read mux, flush bit always reads 0
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      reg_ctrl:   cfg_rdata[ctrl_enable_bit] = enable;
      reg_thresh: cfg_rdata = thresh;
      reg_ovf:    cfg_rdata = ovf_cnt;
      reg_unf:    cfg_rdata = unf_cnt;
      default:    cfg_rdata = '0;
    endcase
  end

  // threshold of 0 keeps almost_full high
  assign almost_full = cfg_data_w'(level) >= thresh;

  a_flush_single : assert property (
    @(posedge clk) disable iff (!rst_n)
    flush |=> !flush
  ) else $error("flush held for two cycles");

endmodule

`default_nettype wire

// File: rtl/preview_fifo.sv
// ----------------------------------------------------------------------
// ring buffer with one or two writes and a two-word preview per cycle
// the shift is judged against the level before the write, then the write
// a write that does not fit is dropped whole and flagged on ovf_pulse
// flush empties the buffer and discards that cycle's requests
// od0 and od1 hold stale data while their valid flags are low
// ----------------------------------------------------------------------
`default_nettype none
`timescale 1ns/1ps

module preview_fifo
  import preview_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,

  // producer side
  input  logic               wrreq,
  input  logic               ena,
  input  logic [data_w-1:0]  id0,
  input  logic [data_w-1:0]  id1,

  // consumer side
  input  logic [shift_w-1:0] shift_req_oh,

  // from the register block
  input  logic               enable,
  input  logic               flush,

  // preview outputs
  output logic               valid,
  output logic               valid2,
  output logic [data_w-1:0]  od0,
  output logic [data_w-1:0]  od1,

  // status and events
  output logic [level_w-1:0] level,
  output logic               ovf_pulse,
  output logic               unf_pulse
);

  localparam logic [level_w-1:0] depth_lvl = level_w'(fifo_depth);

  logic [data_w-1:0]  mem [fifo_depth];

  logic [ptr_w-1:0]   rd_ptr;
  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr_p1;
  logic [ptr_w-1:0]   wr_ptr_p1;

  logic [1:0]         shift_cnt;
  logic [1:0]         shift_grant;
  logic               unf_hit;
  logic [level_w-1:0] level_kept;
  logic [level_w-1:0] room;
  logic [1:0]         wr_cnt;
  logic [1:0]         wr_grant;
  logic               ovf_hit;

  assign rd_ptr_p1 = rd_ptr + ptr_w'(1);
  assign wr_ptr_p1 = wr_ptr + ptr_w'(1);

  // ----------------------------------------------------------------------
  // request decode and grant
  // ----------------------------------------------------------------------
  always_comb begin
    case (shift_req_oh)
      shift_hold: shift_cnt = 2'd0;
      shift_one:  shift_cnt = 2'd1;
      shift_two:  shift_cnt = 2'd2;
      default:    shift_cnt = 2'd0;
    endcase

    // retiring more than is stored is refused outright
    unf_hit     = level_w'(shift_cnt) > level;
    shift_grant = unf_hit ? 2'd0 : shift_cnt;
    level_kept  = level - level_w'(shift_grant);

    // room counts the slots freed by this cycle's shift
    room = depth_lvl - level_kept;

    if (!wrreq) begin
      wr_cnt = 2'd0;
    end else if (ena) begin
      wr_cnt = 2'd2;
    end else begin
      wr_cnt = 2'd1;
    end

    // disabled writes are neither stored nor counted
    ovf_hit  = enable && (level_w'(wr_cnt) > room);
    wr_grant = (enable && !ovf_hit) ? wr_cnt : 2'd0;
  end

  // ----------------------------------------------------------------------
  // pointers, level and event pulses
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      level     <= '0;
      ovf_pulse <= 1'b0;
      unf_pulse <= 1'b0;
    end else if (flush) begin
      rd_ptr    <= '0;
      wr_ptr    <= '0;
      level     <= '0;
      ovf_pulse <= 1'b0;
      unf_pulse <= 1'b0;
    end else begin
      rd_ptr    <= rd_ptr + ptr_w'(shift_grant);
      wr_ptr    <= wr_ptr + ptr_w'(wr_grant);
      level     <= level_kept + level_w'(wr_grant);
      ovf_pulse <= ovf_hit;
      unf_pulse <= unf_hit;
    end
  end

  // storage
  // on a full buffer with a retire, wr_ptr lands on a slot freed this cycle
  always_ff @(posedge clk) begin
    if (!flush) begin
      if (wr_grant != 2'd0) begin
        mem[wr_ptr] <= id0;
      end
      if (wr_grant == 2'd2) begin
        mem[wr_ptr_p1] <= id1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // preview
  // ----------------------------------------------------------------------
  assign od0    = mem[rd_ptr];
  assign od1    = mem[rd_ptr_p1];
  assign valid  = level != '0;
  assign valid2 = level >= level_w'(2);

  // consumer may raise at most one retire code
  a_shift_onehot : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(shift_req_oh)
  ) else $error("shift_req_oh is not one-hot: %b", shift_req_oh);

  // grant logic keeps the fill within the array across every update
  a_level_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    level <= depth_lvl
  ) else $error("level %0d beyond depth", level);

  a_valid_order : assert property (
    @(posedge clk) disable iff (!rst_n)
    valid2 |-> valid
  ) else $error("valid2 without valid");

endmodule

`default_nettype wire

// File: rtl/preview_pkg.sv
// ----------------------------------------------------------------------
// shared widths, shift codes and register map of the preview FIFO
// fifo_depth must stay a power of two, the pointers wrap by overflow
// level_w holds 0 to fifo_depth inclusive
// ----------------------------------------------------------------------
`default_nettype none

package preview_pkg;

  // data path
  localparam int unsigned data_w     = 16;
  localparam int unsigned fifo_depth = 16;
  localparam int unsigned ptr_w      = $clog2(fifo_depth);
  localparam int unsigned level_w    = ptr_w + 1;

  // one-hot retire request from the consumer
  localparam int unsigned         shift_w    = 3;
  localparam logic [shift_w-1:0] shift_hold = 3'b001;
  localparam logic [shift_w-1:0] shift_one  = 3'b010;
  localparam logic [shift_w-1:0] shift_two  = 3'b100;

  // ----------------------------------------------------------------------
  // config bus
  // ----------------------------------------------------------------------
  localparam int unsigned cfg_addr_w = 2;
  localparam int unsigned cfg_data_w = 16;

  localparam logic [cfg_addr_w-1:0] reg_ctrl   = 2'd0;
  localparam logic [cfg_addr_w-1:0] reg_thresh = 2'd1;
  localparam logic [cfg_addr_w-1:0] reg_ovf    = 2'd2;
  localparam logic [cfg_addr_w-1:0] reg_unf    = 2'd3;

  // ctrl register fields
  localparam int unsigned ctrl_enable_bit = 0;
  localparam int unsigned ctrl_flush_bit  = 1;

  // almost_full point after reset
  localparam logic [cfg_data_w-1:0] thresh_reset = 16'd12;

endpackage

`default_nettype wire
